//--- design/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;

    localparam logic [6:0] opcode_r = 7'b0110011; // Register-register arithmetic.
    localparam logic [6:0] opcode_i = 7'b0010011; // Register-immediate arithmetic.

    // Encoded exactly as funct3.
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_srl  = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_op_t;

    // One fetched word, two field layouts.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_t;

    typedef enum logic [2:0] {
        st_start,
        st_operate,
        st_write_back,
        st_advance_pc,
        st_complete
    } cpu_state_t;

endpackage

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
    parameter int unsigned led_reg = 10
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [4:0]              ra,
    input  logic [4:0]              rb,
    input  logic [4:0]              wa,
    input  logic [rv_pkg::xlen-1:0] wd,
    input  logic                    we,
    output logic [rv_pkg::xlen-1:0] rda,
    output logic [rv_pkg::xlen-1:0] rdb,
    output logic [7:0]              led
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [0:31];

    // Entry 0 is cleared at reset and never written.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;
        end
    end

    assign rda = regs[ra];
    assign rdb = regs[rb];

    assign led = regs[led_reg][7:0]; // Low byte only.

endmodule

//--- design/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    input  rv_pkg::alu_op_t         op,
    input  logic                    alt,
    output logic [rv_pkg::xlen-1:0] y
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add: begin
                y = alt ? (a - b) : (a + b); // Alt selects sub.
            end
            alu_sll: begin
                y = a << shamt;
            end
            alu_slt: begin
                y = {{(xlen-1){1'b0}}, ($signed(a) < $signed(b))};
            end
            alu_sltu: begin
                y = {{(xlen-1){1'b0}}, (a < b)};
            end
            alu_xor: begin
                y = a ^ b;
            end
            alu_srl: begin
                if (alt) begin
                    y = $signed(a) >>> shamt; // Alt selects sra.
                end else begin
                    y = a >> shamt;
                end
            end
            alu_or: begin
                y = a | b;
            end
            alu_and: begin
                y = a & b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

//--- design/datapath.sv
`timescale 1ns/1ps

module datapath #(
    parameter int unsigned led_reg = 10
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [4:0]              rd,
    input  rv_pkg::alu_op_t         alu_op,
    input  logic                    alu_alt,
    input  logic                    alu_src_imm,
    input  logic [rv_pkg::xlen-1:0] imm,
    input  logic                    reg_write,
    output logic [7:0]              led
);
    import rv_pkg::*;

    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] alu_result;

    assign operand_b = alu_src_imm ? imm : rs2_data; // Immediate for I-type.

    reg_file #(
        .led_reg(led_reg)
    ) u_reg_file (
        .clk  (clk),
        .rst_n(rst_n),
        .ra   (rs1),
        .rb   (rs2),
        .wa   (rd),
        .wd   (alu_result),
        .we   (reg_write),
        .rda  (rs1_data),
        .rdb  (rs2_data),
        .led  (led)
    );

    alu u_alu (
        .a  (rs1_data),
        .b  (operand_b),
        .op (alu_op),
        .alt(alu_alt),
        .y  (alu_result)
    );

endmodule

//--- design/control_fsm.sv
`timescale 1ns/1ps

module control_fsm #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv_pkg::instr_t          instruction,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2,
    output logic [4:0]              rd,
    output rv_pkg::alu_op_t         alu_op,
    output logic                    alu_alt,
    output logic                    alu_src_imm,
    output logic [rv_pkg::xlen-1:0] imm,
    output logic                    reg_write
);
    import rv_pkg::*;

    cpu_state_t state;
    instr_t     ir;
    logic       fetch_arith;
    logic       is_r_type;
    logic       is_i_type;

    // Decided on the live word, before it is latched.
    assign fetch_arith = (instruction.r.opcode == opcode_r) ||
                         (instruction.i.opcode == opcode_i);

    assign is_r_type = (ir.r.opcode == opcode_r);
    assign is_i_type = (ir.i.opcode == opcode_i);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_start;
            ir    <= '0;
        end else begin
            case (state)
                st_start: begin
                    ir <= instruction;
                    if (fetch_arith) begin
                        state <= st_operate;
                    end else begin
                        state <= st_advance_pc; // No-op skips two states.
                    end
                end
                st_operate: begin
                    state <= st_write_back;
                end
                st_write_back: begin
                    state <= st_advance_pc;
                end
                st_advance_pc: begin
                    state <= st_complete;
                end
                st_complete: begin
                    state <= st_start;
                end
                default: begin
                    state <= st_start;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (state == st_advance_pc) begin
            pc <= pc + xlen'(4);
        end
    end

    assign rs1    = ir.i.rs1;
    assign rs2    = ir.r.rs2;
    assign rd     = ir.r.rd;
    assign alu_op = alu_op_t'(ir.r.funct3);

    assign imm = {{(xlen-12){ir.i.imm[11]}}, ir.i.imm}; // Sign-extended.

    // Only srai borrows the funct7 bit among immediates.
    always_comb begin
        if (is_r_type) begin
            alu_alt = ir.r.funct7[5];
        end else if (is_i_type && (alu_op == alu_srl)) begin
            alu_alt = ir.i.imm[10];
        end else begin
            alu_alt = 1'b0;
        end
    end

    assign alu_src_imm = is_i_type;
    assign reg_write   = (state == st_write_back);

endmodule

//--- design/cpu.sv
`timescale 1ns/1ps

module cpu #(
    parameter int unsigned             led_reg  = 10,
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv_pkg::instr_t          instruction,
    output logic [7:0]              led,
    output logic [rv_pkg::xlen-1:0] pc
);
    import rv_pkg::*;

    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    alu_op_t         alu_op;
    logic            alu_alt;
    logic            alu_src_imm;
    logic [xlen-1:0] imm;
    logic            reg_write;

    control_fsm #(
        .reset_pc(reset_pc)
    ) u_control_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .instruction(instruction),
        .pc         (pc),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .alu_op     (alu_op),
        .alu_alt    (alu_alt),
        .alu_src_imm(alu_src_imm),
        .imm        (imm),
        .reg_write  (reg_write)
    );

    datapath #(
        .led_reg(led_reg)
    ) u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .alu_op     (alu_op),
        .alu_alt    (alu_alt),
        .alu_src_imm(alu_src_imm),
        .imm        (imm),
        .reg_write  (reg_write),
        .led        (led)
    );

endmodule

//--- bench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Fibonacci form, taps at 32, 22, 2 and 1.
function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

function automatic logic [31:0] make_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] funct3,
                                       input logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, opcode_r};
endfunction

function automatic logic [31:0] make_i(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] funct3, input logic [4:0] rd);
    return {imm, rs1, funct3, rd, opcode_i};
endfunction

function automatic logic is_arith(input logic [31:0] w);
    return (w[6:0] == opcode_r) || (w[6:0] == opcode_i);
endfunction

// RV32I result for one arithmetic word.
function automatic logic [31:0] expected_alu(input logic [31:0] w, input logic [31:0] a,
                                             input logic [31:0] r2);
    logic [31:0] b;
    logic        alt;
    logic [4:0]  sh;
    logic [31:0] y;
    if (w[6:0] == opcode_i) begin
        b   = {{20{w[31]}}, w[31:20]};
        alt = (w[14:12] == 3'b101) && w[30]; // srai only.
    end else begin
        b   = r2;
        alt = w[30];
    end
    sh = b[4:0];
    case (w[14:12])
        3'b000:  y = alt ? (a - b) : (a + b);
        3'b001:  y = a << sh;
        3'b010:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  y = (a < b) ? 32'd1 : 32'd0;
        3'b100:  y = a ^ b;
        3'b101:  y = alt ? $unsigned($signed(a) >>> sh) : (a >> sh);
        3'b110:  y = a | b;
        default: y = a & b;
    endcase
    return y;
endfunction

`endif

//--- bench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    import rv_pkg::*;

    localparam logic [31:0] lfsr_seed    = 32'h4fd2_2296;
    localparam int          prog_len     = 64;
    localparam int          reset_cycles = 16;
    localparam int          gap_limit    = 12;
    localparam int          led_index    = 10;

    logic        clk;
    logic        rst_n;
    instr_t      instruction;
    logic [7:0]  led;
    logic [31:0] pc;

    logic [31:0] prog [0:prog_len-1];
    logic [31:0] shadow [0:31];
    logic [31:0] lfsr_state;

    `include "tb_model.svh"

    cpu dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .instruction(instruction),
        .led        (led),
        .pc         (pc)
    );

    always #5 clk = ~clk;

    // Word for the current pc is held until pc moves.
    always @(posedge clk) begin
        if ($isunknown(pc)) begin
            instruction <= '0;
        end else begin
            instruction <= prog[pc[7:2]];
        end
    end

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        value_match: assert (actual === expected) else begin
            $display("error %s: expected %h actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    pc_step: assert property (@(posedge clk) disable iff (!rst_n)
        (pc != $past(pc)) |-> (pc == $past(pc) + 32'd4))
    else begin
        $display("error pc_step: expected %h actual %h",
                 $past(pc) + 32'd4, $sampled(pc));
        stop_run();
    end

    led_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(led))
    else begin
        $display("led output went unknown after reset");
        stop_run();
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = next_lfsr(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] random_instr();
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic [2:0]  rd_pick;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic        alt;
        logic [6:0]  opc;
        kind    = 4'(take_bits(4));
        f3      = 3'(take_bits(3));
        rd_pick = 3'(take_bits(3));
        rs1     = 5'(take_bits(4));
        rs2     = 5'(take_bits(4));
        imm     = 12'(take_bits(12));
        alt     = 1'(take_bits(1));
        if (rd_pick < 3'd3) begin
            rd = 5'd10; // Lands on the LED register.
        end else if (rd_pick == 3'd3) begin
            rd = 5'd0;
        end else begin
            rd = 5'(take_bits(4));
        end
        if (kind == 4'd0) begin
            opc = 7'(take_bits(7));
            if ((opc == opcode_r) || (opc == opcode_i)) begin
                opc = 7'h7f;
            end
            return {imm, rs1, f3, rd, opc};
        end else if (kind < 4'd8) begin
            return make_r((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                          rs2, rs1, f3, rd);
        end else begin
            if (f3 == 3'b001) begin
                imm[11:5] = 7'h00;
            end else if (f3 == 3'b101) begin
                imm[11:5] = alt ? 7'h20 : 7'h00;
            end
            return make_i(imm, rs1, f3, rd);
        end
    endfunction

    task automatic build_program();
        prog[0] = 32'h0000_0000; // Illegal opcode.
        for (int r = 1; r < 16; r++) begin
            prog[r] = make_i(12'(take_bits(12)), 5'd0, 3'b000, 5'(r));
        end
        prog[3]  = make_i(12'h9a5, 5'd0, 3'b000, 5'd3); // Negative source for srai.
        prog[16] = make_i(12'h07b, 5'd0, 3'b000, 5'd0); // Write to x0.
        prog[17] = make_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd10);
        prog[18] = make_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd10); // sub
        prog[19] = make_i(12'h41c, 5'd3, 3'b101, 5'd10); // srai by 28
        for (int k = 20; k < prog_len; k++) begin
            prog[k] = random_instr();
        end
    endtask

    task automatic wait_pc_change(input logic [31:0] old_pc, output int cycles);
        cpu_state_t st;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > gap_limit) begin
                st = dut.u_control_fsm.state;
                $display("timeout: pc stayed at %h for %0d cycles in state %s",
                         old_pc, gap_limit, st.name());
                stop_run();
            end
        end while (pc == old_pc);
    endtask

    task automatic apply_model(input logic [31:0] w);
        logic [4:0] rd_idx;
        rd_idx = w[11:7];
        if (is_arith(w) && (rd_idx != 5'd0)) begin
            shadow[rd_idx] = expected_alu(w, shadow[w[19:15]], shadow[w[24:20]]);
        end
    endtask

    initial begin
        logic [31:0] last_pc;
        logic [31:0] word;
        int          gap;
        int          expected_gap;
        clk         = 1'b0;
        rst_n       = 1'b0;
        instruction = '0;
        lfsr_state  = lfsr_seed;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        build_program();
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset_pc", 32'd0, pc);
        check_value("reset_led", 32'd0, {24'd0, led});
        last_pc = pc;
        for (int k = 0; k < prog_len; k++) begin
            wait_pc_change(last_pc, gap);
            word         = prog[k];
            expected_gap = is_arith(word) ? 5 : 3;
            if (k == 0) begin
                expected_gap = expected_gap - 1; // Counted from reset release.
            end
            check_value($sformatf("gap_%0d", k), expected_gap, gap);
            check_value($sformatf("pc_%0d", k), last_pc + 32'd4, pc);
            apply_model(word);
            check_value($sformatf("led_%0d", k), {24'd0, shadow[led_index][7:0]},
                        {24'd0, led});
            last_pc = pc;
        end
        for (int r = 0; r < 16; r++) begin
            check_value($sformatf("x%0d_final", r), shadow[r],
                        dut.u_datapath.u_reg_file.regs[r]);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+bench
design/rv_pkg.sv
design/reg_file.sv
design/alu.sv
design/datapath.sv
design/control_fsm.sv
design/cpu.sv
bench/cpu_tb.sv
